//--- vlog.f
+incdir+hdl
hdl/breakout_pkg.sv
hdl/paddle_motion.sv
hdl/ball_motion.sv
hdl/life_counter.sv
hdl/heart_display.sv
hdl/pixel_renderer.sv
hdl/breakout_top.sv
verification/breakout_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator from the project root, then look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module breakout_tb -f vlog.f -o breakout_sim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/breakout_sim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" ||
	{ cat sim.log; echo "Simulation failed"; exit 1; }

//--- verification/breakout_stimulus.txt
# op btn_left btn_right x y red green blue lives
# TICK runs x frames and checks lives after; PROBE shows pixel (x,y) and checks colour
PROBE 0 0 1 300 0 7 0 3
PROBE 0 0 450 552 0 0 7 3
PROBE 0 0 403 403 7 0 0 3
PROBE 0 0 710 570 14 0 3 3
PROBE 0 0 780 570 14 0 3 3
TICK 0 1 10 0 0 0 0 3
PROBE 0 0 439 552 0 0 7 3
PROBE 0 0 438 552 0 0 0 3
TICK 0 1 60 0 0 0 0 3
PROBE 0 0 659 552 0 0 7 3
PROBE 0 0 658 552 0 0 0 3
TICK 0 0 25 0 0 0 0 3
TICK 0 0 1 0 0 0 0 2
PROBE 0 0 403 403 7 0 0 2
PROBE 0 0 780 570 0 0 0 2
TICK 1 0 64 0 0 0 0 2
PROBE 0 0 403 552 0 0 7 2
PROBE 0 0 403 531 7 0 0 2
TICK 0 0 8 0 0 0 0 2
PROBE 0 0 403 544 7 0 0 2
PROBE 0 0 403 543 0 0 0 2
TICK 0 0 10 0 0 0 0 2
PROBE 0 0 383 534 7 0 0 2
PROBE 0 0 383 533 0 0 0 2
TICK 0 0 188 0 0 0 0 2
PROBE 0 0 7 349 7 0 0 2
TICK 0 0 636 0 0 0 0 2
PROBE 0 0 307 592 7 0 0 2
TICK 0 0 1 0 0 0 0 1
PROBE 0 0 710 570 14 0 3 1
TICK 0 1 95 0 0 0 0 1
TICK 0 0 1 0 0 0 0 0
PROBE 0 0 403 403 7 0 0 0
PROBE 0 0 710 570 0 0 0 0
TICK 0 0 96 0 0 0 0 0
TICK 0 0 5 0 0 0 0 0
PROBE 0 0 403 595 7 0 0 0
TICK 1 0 1 0 0 0 0 3
PROBE 0 0 403 403 7 0 0 3
PROBE 0 0 780 570 14 0 3 3
PROBE 0 0 655 552 0 0 7 3
PROBE 0 0 654 552 0 0 0 3

//--- verification/breakout_tb.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module breakout_tb;

	// Blanked random pixels before every frame tick
	localparam int filler_cycles = 3;
	localparam int drive_delay = 2;
	localparam logic [63:0] op_tick = 64'("TICK");
	localparam logic [63:0] op_probe = 64'("PROBE");

	// One line of the stimulus file
	typedef struct {
		logic is_tick;
		int   btn_left;
		int   btn_right;
		int   x;
		int   y;
		int   red;
		int   green;
		int   blue;
		int   lives;
	} step_t;

	logic                 clk;
	logic                 reset;
	logic                 btn_left;
	logic                 btn_right;
	logic                 video_on;
	breakout_pkg::coord_t pix_x;
	breakout_pkg::coord_t pix_y;
	breakout_pkg::color_t red;
	breakout_pkg::color_t green;
	breakout_pkg::color_t blue;
	breakout_pkg::lives_t lives;

	step_t steps[$];
	int    seed;
	int    cycle_count;
	int    cycle_limit;

	breakout_top DUT (.clk(clk), .reset(reset), .btn_left(btn_left), .btn_right(btn_right),
		.video_on(video_on), .pix_x(pix_x), .pix_y(pix_y), .red(red), .green(green),
		.blue(blue), .lives(lives));

	// 40 ns period
	always #20 clk = ~clk;

	task automatic stop_on_failure();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	// Run-length guard, limit known once the file is read
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout: the run went past %0d clock cycles", cycle_limit);
			stop_on_failure();
		end
	end

	task automatic check_value(input string name, input int actual, input int expected);
		assert (actual == expected) else begin
			$display("Error: at %0d ns %s is %0d, expected %0d", $time, name, actual, expected);
			stop_on_failure();
		end
	endtask

	task automatic check_colour(input int r, input int g, input int b);
		check_value("red", int'(red), r);
		check_value("green", int'(green), g);
		check_value("blue", int'(blue), b);
	endtask

	// Drive a pixel just after the edge, return after the next edge has registered it
	task automatic present_pixel(input int x, input int y, input logic von);
		pix_x = breakout_pkg::coord_t'(x);
		pix_y = breakout_pkg::coord_t'(y);
		video_on = von;
		@(posedge clk);
		#drive_delay;
	endtask

	// Random blanked pixel, never on the tick row
	task automatic show_filler();
		int x;
		int y;
		x = int'($unsigned($random(seed)) % `SCREEN_W);
		y = int'($unsigned($random(seed)) % `SCREEN_H);
		present_pixel(x, y, 1'b0);
		check_colour(0, 0, 0);
	endtask

	task automatic run_ticks(input int count);
		repeat (count) begin
			repeat (filler_cycles) show_filler();
			// Tick pixel sits in the blanking area too
			present_pixel(0, `FRAME_TICK_Y, 1'b0);
			check_colour(0, 0, 0);
		end
	endtask

	// Whole file into the queue, cycle budget from its ticks and probes
	task automatic load_stimulus();
		int          fd;
		int          count;
		string       line;
		logic [63:0] op;
		step_t       s;
		fd = $fopen("verification/breakout_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			stop_on_failure();
		end
		// Reset cycles plus slack
		cycle_limit = 20;
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				count = $sscanf(line, "%s %d %d %d %d %d %d %d %d", op, s.btn_left,
					s.btn_right, s.x, s.y, s.red, s.green, s.blue, s.lives);
				if (count != 9 || (op != op_tick && op != op_probe)) begin
					$display("Malformed stimulus line: %s", line);
					stop_on_failure();
				end
				s.is_tick = (op == op_tick);
				steps.push_back(s);
				if (s.is_tick) begin
					cycle_limit = cycle_limit + s.x * (filler_cycles + 1);
				end else begin
					cycle_limit = cycle_limit + 1;
				end
			end
		end
		$fclose(fd);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		btn_left = 1'b0;
		btn_right = 1'b0;
		video_on = 1'b0;
		pix_x = '0;
		pix_y = '0;
		seed = 78320;
		cycle_count = 0;
		cycle_limit = 0;
		load_stimulus();
		repeat (5) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		foreach (steps[i]) begin
			// Buttons held for the whole step
			btn_left = (steps[i].btn_left != 0);
			btn_right = (steps[i].btn_right != 0);
			if (steps[i].is_tick) begin
				run_ticks(steps[i].x);
			end else begin
				present_pixel(steps[i].x, steps[i].y, 1'b1);
				check_colour(steps[i].red, steps[i].green, steps[i].blue);
			end
			check_value("lives", int'(lives), steps[i].lives);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- hdl/breakout_top.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module breakout_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 btn_left,
	input  logic                 btn_right,
	input  logic                 video_on,
	input  breakout_pkg::coord_t pix_x,
	input  breakout_pkg::coord_t pix_y,
	output breakout_pkg::color_t red,
	output breakout_pkg::color_t green,
	output breakout_pkg::color_t blue,
	output breakout_pkg::lives_t lives
);

	logic                 frame_tick;
	logic                 miss;
	logic                 serve;
	logic                 running;
	logic                 heart_on;
	breakout_pkg::coord_t paddle_x;
	breakout_pkg::coord_t ball_x;
	breakout_pkg::coord_t ball_y;

	// One-clock strobe per frame, below the visible area
	assign frame_tick = (pix_x == '0) && (pix_y == breakout_pkg::coord_t'(`FRAME_TICK_Y));

	paddle_motion u_paddle (.clk(clk), .reset(reset), .frame_tick(frame_tick),
		.btn_left(btn_left), .btn_right(btn_right), .paddle_x(paddle_x));

	ball_motion u_ball (.clk(clk), .reset(reset), .frame_tick(frame_tick), .serve(serve),
		.running(running), .paddle_x(paddle_x), .ball_x(ball_x), .ball_y(ball_y),
		.miss(miss));

	// Lives and game-over hold
	life_counter u_lives (.clk(clk), .reset(reset), .frame_tick(frame_tick), .miss(miss),
		.btn_left(btn_left), .btn_right(btn_right), .lives(lives), .serve(serve),
		.running(running));

	heart_display u_hearts (.pix_x(pix_x), .pix_y(pix_y), .lives(lives),
		.heart_on(heart_on));

	pixel_renderer u_render (.clk(clk), .reset(reset), .video_on(video_on), .pix_x(pix_x),
		.pix_y(pix_y), .paddle_x(paddle_x), .ball_x(ball_x), .ball_y(ball_y),
		.heart_on(heart_on), .red(red), .green(green), .blue(blue));

endmodule

//--- hdl/pixel_renderer.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module pixel_renderer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 video_on,
	input  breakout_pkg::coord_t pix_x,
	input  breakout_pkg::coord_t pix_y,
	input  breakout_pkg::coord_t paddle_x,
	input  breakout_pkg::coord_t ball_x,
	input  breakout_pkg::coord_t ball_y,
	input  logic                 heart_on,
	output breakout_pkg::color_t red,
	output breakout_pkg::color_t green,
	output breakout_pkg::color_t blue
);

	logic                 wall_on;
	logic                 paddle_on;
	logic                 ball_box;
	logic                 ball_on;
	breakout_pkg::coord_t ball_col;
	breakout_pkg::coord_t ball_row;
	logic [7:0]           ball_rom;

	// Left, top and right strips; open at the bottom
	assign wall_on = (pix_x <= breakout_pkg::coord_t'(`WALL_LEFT_R)) ||
		(pix_y <= breakout_pkg::coord_t'(`WALL_TOP_B)) ||
		(pix_x >= breakout_pkg::coord_t'(`WALL_RIGHT_L));

	// Paddle box on its fixed row
	assign paddle_on = (pix_x >= paddle_x) &&
		(pix_x <= paddle_x + breakout_pkg::coord_t'(`PADDLE_W - 1)) &&
		(pix_y >= breakout_pkg::coord_t'(`PADDLE_Y)) &&
		(pix_y <= breakout_pkg::coord_t'(`PADDLE_Y + `PADDLE_H - 1));

	// Offsets inside the ball box
	assign ball_col = pix_x - ball_x;
	assign ball_row = pix_y - ball_y;
	assign ball_box = (pix_x >= ball_x) && (pix_y >= ball_y) &&
		(ball_col < breakout_pkg::coord_t'(`BALL_SIZE)) &&
		(ball_row < breakout_pkg::coord_t'(`BALL_SIZE));

	// Round ball mask
	always_comb begin
		case (ball_row[2:0])
			3'd0, 3'd7: ball_rom = 8'h3C;
			3'd1, 3'd6: ball_rom = 8'h7E;
			default: ball_rom = 8'hFF;
		endcase
	end

	assign ball_on = ball_box && ball_rom[ball_col[2:0]];

	// Colour mux, one clock behind the pixel
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			{red, green, blue} <= '0;
		end else if (!video_on) begin
			{red, green, blue} <= '0;
		end else if (wall_on) begin
			{red, green, blue} <= `WALL_RGB;
		end else if (paddle_on) begin
			{red, green, blue} <= `PADDLE_RGB;
		end else if (ball_on) begin
			{red, green, blue} <= `BALL_RGB;
		end else if (heart_on) begin
			{red, green, blue} <= `HEART_RGB;
		end else begin
			// Background
			{red, green, blue} <= '0;
		end
	end

endmodule

//--- hdl/heart_display.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module heart_display (
	input  breakout_pkg::coord_t pix_x,
	input  breakout_pkg::coord_t pix_y,
	input  breakout_pkg::lives_t lives,
	output logic                 heart_on
);

	// Left edges of the three heart boxes
	localparam breakout_pkg::coord_t heart_x [3] = '{
		breakout_pkg::coord_t'(`HEART0_X),
		breakout_pkg::coord_t'(`HEART1_X),
		breakout_pkg::coord_t'(`HEART2_X)
	};

	breakout_pkg::coord_t row;
	logic                 in_rows;
	logic [31:0]          rom_data;

	// Row inside the heart band, shared by all hearts
	assign row = pix_y - breakout_pkg::coord_t'(`HEART_Y);
	assign in_rows = (pix_y >= breakout_pkg::coord_t'(`HEART_Y)) &&
		(pix_y < breakout_pkg::coord_t'(`HEART_Y + `HEART_SIZE));

	// Heart image, bit index is the column from the box's left edge
	always_comb begin
		case (row[3:0])
			4'h2: rom_data = 32'h0F01E000;
			4'h3: rom_data = 32'h3FC7F800;
			4'h4: rom_data = 32'h7FFFFC00;
			4'h5: rom_data = 32'hFFFFFE00;
			4'h6: rom_data = 32'hFFFFFE00;
			4'h7: rom_data = 32'h7FFFFC00;
			4'h8: rom_data = 32'h3FFFF800;
			4'h9: rom_data = 32'h1FFFF000;
			4'hA: rom_data = 32'h07FFC000;
			4'hB: rom_data = 32'h01FF0000;
			4'hC: rom_data = 32'h007C0000;
			4'hD: rom_data = 32'h00100000;
			default: rom_data = 32'h00000000;
		endcase
	end

	// Lower half of the box is blank
	always_comb begin
		breakout_pkg::coord_t col;
		heart_on = 1'b0;
		for (int k = 0; k < 3; k++) begin
			col = pix_x - heart_x[k];
			// Unlit hearts draw nothing
			if (k < int'(lives) && in_rows && !row[4] && pix_x >= heart_x[k] &&
				col < breakout_pkg::coord_t'(`HEART_SIZE)) begin
				heart_on = heart_on | rom_data[col[4:0]];
			end
		end
	end

endmodule

//--- hdl/life_counter.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module life_counter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 frame_tick,
	input  logic                 miss,
	input  logic                 btn_left,
	input  logic                 btn_right,
	output breakout_pkg::lives_t lives,
	output logic                 serve,
	output logic                 running
);

	breakout_pkg::game_state_e state;

	assign running = (state == breakout_pkg::PLAY);

	// Serve on a miss with lives left or on restart
	assign serve = frame_tick &&
		((running && miss && lives != '0) ||
		(state == breakout_pkg::GAME_OVER && (btn_left || btn_right)));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= breakout_pkg::PLAY;
			lives <= breakout_pkg::lives_t'(`LIVES_START);
		end else if (frame_tick) begin
			case (state)
				breakout_pkg::PLAY: begin
					if (miss && lives != '0) begin
						lives <= lives - 1'b1;
					end else if (miss) begin
						// Out of lives so hold until a button
						state <= breakout_pkg::GAME_OVER;
					end
				end
				breakout_pkg::GAME_OVER: begin
					if (btn_left || btn_right) begin
						state <= breakout_pkg::PLAY;
						lives <= breakout_pkg::lives_t'(`LIVES_START);
					end
				end
				default: state <= breakout_pkg::PLAY;
			endcase
		end
	end

	// Lives go up only on a restart and never wrap below zero
	a_lives_rise_on_restart: assert property (@(posedge clk) disable iff (reset)
		lives > $past(lives) |-> $past(state) == breakout_pkg::GAME_OVER);

endmodule

//--- hdl/ball_motion.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module ball_motion (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 frame_tick,
	input  logic                 serve,
	input  logic                 running,
	input  breakout_pkg::coord_t paddle_x,
	output breakout_pkg::coord_t ball_x,
	output breakout_pkg::coord_t ball_y,
	output logic                 miss
);

	// Current velocity and the one picked for the next frame
	breakout_pkg::velocity_t vel_x;
	breakout_pkg::velocity_t vel_y;
	breakout_pkg::velocity_t vel_x_next;
	breakout_pkg::velocity_t vel_y_next;
	// Current bottom edge
	breakout_pkg::coord_t    ball_y_b;
	// Position after this frame's step
	breakout_pkg::coord_t    next_x;
	breakout_pkg::coord_t    next_y;
	breakout_pkg::coord_t    next_x_r;
	breakout_pkg::coord_t    next_y_b;
	breakout_pkg::coord_t    paddle_r;
	logic                    paddle_hit;

	assign ball_y_b = ball_y + breakout_pkg::coord_t'(`BALL_SIZE - 1);
	assign miss = ball_y_b >= breakout_pkg::coord_t'(`MISS_LINE);

	// Step ahead with a wrap-around add for negative speeds
	assign next_x = ball_x + breakout_pkg::coord_t'(vel_x);
	assign next_y = ball_y + breakout_pkg::coord_t'(vel_y);
	assign next_x_r = next_x + breakout_pkg::coord_t'(`BALL_SIZE - 1);
	assign next_y_b = next_y + breakout_pkg::coord_t'(`BALL_SIZE - 1);
	assign paddle_r = paddle_x + breakout_pkg::coord_t'(`PADDLE_W - 1);

	// Right edge inside the paddle span and rows across the paddle rows
	assign paddle_hit = (next_x_r >= paddle_x) && (next_x_r <= paddle_r) &&
		(next_y_b >= breakout_pkg::coord_t'(`PADDLE_Y)) &&
		(next_y <= breakout_pkg::coord_t'(`PADDLE_Y + `PADDLE_H - 1));

	// Bounce choice from the stepped position
	always_comb begin
		vel_y_next = vel_y;
		if (next_y <= breakout_pkg::coord_t'(`WALL_TOP_B)) begin
			vel_y_next = breakout_pkg::velocity_t'(`BALL_SPEED_Y_DOWN);
		end else if (paddle_hit) begin
			// Slower on the way up
			vel_y_next = breakout_pkg::velocity_t'(-`BALL_SPEED_Y_UP);
		end

		vel_x_next = vel_x;
		if (paddle_hit) begin
			vel_x_next = breakout_pkg::velocity_t'(-`BALL_SPEED_X);
		end
		// Walls override the paddle
		if (next_x <= breakout_pkg::coord_t'(`WALL_LEFT_R)) begin
			vel_x_next = breakout_pkg::velocity_t'(`BALL_SPEED_X);
		end else if (next_x_r >= breakout_pkg::coord_t'(`WALL_RIGHT_L)) begin
			vel_x_next = breakout_pkg::velocity_t'(-`BALL_SPEED_X);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ball_x <= breakout_pkg::coord_t'(`BALL_X_START);
			ball_y <= breakout_pkg::coord_t'(`BALL_Y_START);
			vel_x <= '0;
			vel_y <= breakout_pkg::velocity_t'(`BALL_SPEED_Y_DOWN);
		end else if (serve) begin
			// Back to the centre and straight down
			ball_x <= breakout_pkg::coord_t'(`BALL_X_START);
			ball_y <= breakout_pkg::coord_t'(`BALL_Y_START);
			vel_x <= '0;
			vel_y <= breakout_pkg::velocity_t'(`BALL_SPEED_Y_DOWN);
		end else if (frame_tick && running) begin
			ball_x <= next_x;
			ball_y <= next_y;
			vel_x <= vel_x_next;
			vel_y <= vel_y_next;
		end
	end

	// A serve never takes the place of a step for a ball still in play
	a_serve_on_miss: assert property (@(posedge clk) disable iff (reset)
		serve |-> frame_tick && (miss || !running));

	// Frozen or served before leaving the screen
	a_ball_on_screen: assert property (@(posedge clk) disable iff (reset)
		ball_y_b < breakout_pkg::coord_t'(`SCREEN_H));

endmodule

//--- hdl/paddle_motion.sv
`timescale 1ns/1ps
`include "breakout_settings.svh"

module paddle_motion (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 frame_tick,
	input  logic                 btn_left,
	input  logic                 btn_right,
	output breakout_pkg::coord_t paddle_x
);

	// Right edge of the paddle box
	breakout_pkg::coord_t paddle_r;

	assign paddle_r = paddle_x + breakout_pkg::coord_t'(`PADDLE_W - 1);

	// One step per frame, right button wins
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			paddle_x <= breakout_pkg::coord_t'(`PADDLE_X_START);
		end else if (frame_tick) begin
			if (btn_right && paddle_r < breakout_pkg::coord_t'(`SCREEN_W - 1 - `PADDLE_STEP)) begin
				paddle_x <= paddle_x + breakout_pkg::coord_t'(`PADDLE_STEP);
			end else if (btn_left && paddle_x > breakout_pkg::coord_t'(`PADDLE_STEP)) begin
				// Left edge stops short of the wall
				paddle_x <= paddle_x - breakout_pkg::coord_t'(`PADDLE_STEP);
			end
		end
	end

	// Paddle never leaves the screen on the right
	a_paddle_on_screen: assert property (@(posedge clk) disable iff (reset)
		frame_tick |=> paddle_r <= breakout_pkg::coord_t'(`SCREEN_W - 1));

endmodule

//--- hdl/breakout_pkg.sv
package breakout_pkg;

	// Pixel or object coordinate
	typedef logic [10:0] coord_t;

	// Per-frame step, two's complement
	typedef logic signed [10:0] velocity_t;

	// One colour channel
	typedef logic [3:0] color_t;

	// Remaining lives, 0 to 3
	typedef logic [1:0] lives_t;

	// Game FSM states
	typedef enum logic {
		PLAY,
		GAME_OVER
	} game_state_e;

endpackage

//--- hdl/breakout_settings.svh
`ifndef BREAKOUT_SETTINGS_SVH
`define BREAKOUT_SETTINGS_SVH

// Visible screen, 800x600
`define SCREEN_W 800
`define SCREEN_H 600
// Frame tick fires here at column 0, just below the visible area
`define FRAME_TICK_Y 601

// Inner edges of the three walls
`define WALL_LEFT_R 3
`define WALL_TOP_B 3
`define WALL_RIGHT_L 796
// Ball bottom at or past this line is a miss
`define MISS_LINE 596

// Paddle box and steering
`define PADDLE_W 140
`define PADDLE_H 10
`define PADDLE_Y 550
`define PADDLE_X_START 399
`define PADDLE_STEP 4

// Ball box, serve point and speeds in pixels per frame
`define BALL_SIZE 8
`define BALL_X_START 399
`define BALL_Y_START 400
`define BALL_SPEED_X 2
`define BALL_SPEED_Y_DOWN 2
`define BALL_SPEED_Y_UP 1

// Life hearts, spaced apart
`define HEART_SIZE 32
`define HEART_Y 565
`define HEART0_X 690
`define HEART1_X 725
`define HEART2_X 760
`define LIVES_START 3

// Colours packed as {red, green, blue}, 4 bits each
`define WALL_RGB 12'h070
`define PADDLE_RGB 12'h007
`define BALL_RGB 12'h700
`define HEART_RGB 12'hE03

`endif
